// File: common/elink_clk_pkg.sv
`default_nettype none

package elink_clk_pkg;

   //############################################################
   // sequencer timing and states
   //############################################################

   localparam int unsigned HB_WIDTH = 4;   // heartbeat every 2**HB_WIDTH cycles

   // reset sequence, one step per heartbeat
   typedef enum logic [2:0]
   {
      RST_ALL    = 3'd0,   // everything held
      START_CCLK = 3'd1,   // core clock running, wait for lock
      STOP_CCLK  = 3'd2,   // quiet clock around chip reset edge
      START_CHIP = 3'd3,   // remote chip out of reset
      HOLD       = 3'd4,   // recheck lock
      TX_ACTIVE  = 3'd5,   // transmit side up
      ACTIVE     = 3'd6    // whole link up
   } rst_state_t;

   //############################################################
   // register port
   //############################################################

   localparam int unsigned AXI_AW = 4;
   localparam int unsigned AXI_DW = 32;

   localparam logic [AXI_AW-1:0] ADDR_CTRL   = 4'h0;
   localparam logic [AXI_AW-1:0] ADDR_STATUS = 4'h4;   // write clears loss info
   localparam logic [AXI_AW-1:0] ADDR_LOSS   = 4'h8;   // read only

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // field positions
   localparam int unsigned CTRL_EN_BIT        = 0;   // soft enable
   localparam int unsigned STAT_CCLK_LOCK_BIT = 4;
   localparam int unsigned STAT_RX_LOCK_BIT   = 5;
   localparam int unsigned STAT_LOST_BIT      = 8;   // sticky core lock loss
   localparam int unsigned LOSS_CNT_W         = 8;   // saturating count

endpackage

`default_nettype wire

// File: rst_seq/rst_heartbeat.sv
`default_nettype none
`timescale 1ns/10ps

module rst_heartbeat
(
   input  logic sys_clk,
   input  logic reset_in,
   output logic heartbeat_o   // one cycle in every 2**HB_WIDTH
);

   logic [elink_clk_pkg::HB_WIDTH-1:0] hb_cnt;       // free running timer
   logic [elink_clk_pkg::HB_WIDTH-1:0] hb_cnt_nxt;

   assign hb_cnt_nxt = hb_cnt + 1'b1;   // plain wrap, no terminal value

   // pulse on the cycle the new count hits zero
   // so the first beat lands a full interval after reset
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         hb_cnt      <= '0;
         heartbeat_o <= 1'b0;
      end
      else
      begin
         hb_cnt      <= hb_cnt_nxt;
         heartbeat_o <= (hb_cnt_nxt == '0);   // registered, glitch free
      end
   end

endmodule

`default_nettype wire

// File: rst_seq/lock_sync.sv
`default_nettype none
`timescale 1ns/10ps

module lock_sync
(
   input  logic sys_clk,
   input  logic reset_in,
   input  logic cclk_locked_i,   // async, core clock pll
   input  logic rx_locked_i,     // async, receive pll
   input  logic elink_en_i,      // async pin
   input  logic soft_en_i,       // from register block
   output logic cclk_lock_o,
   output logic rx_lock_o,
   output logic seq_reset_o      // sequencer restart request
);

   logic [1:0] lock_meta;   // first stage, bit 0 cclk, bit 1 rx
   logic [1:0] lock_sync_q;  // second stage
   logic       rst_req;
   logic       rst_meta;
   logic       rst_sync_q;

   // any of the three sources holds the sequence in reset
   assign rst_req = reset_in | ~elink_en_i | ~soft_en_i;

   //############################################################
   // lock chains, cleared so the fsm never sees a stale lock
   //############################################################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         lock_meta   <= 2'b00;
         lock_sync_q <= 2'b00;
      end
      else
      begin
         lock_meta   <= {rx_locked_i, cclk_locked_i};
         lock_sync_q <= lock_meta;
      end
   end

   //############################################################
   // reset chain, presets to one
   //############################################################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         rst_meta   <= 1'b1;
         rst_sync_q <= 1'b1;
      end
      else
      begin
         rst_meta   <= rst_req;
         rst_sync_q <= rst_meta;
      end
   end

   assign cclk_lock_o = lock_sync_q[0];
   assign rx_lock_o   = lock_sync_q[1];
   assign seq_reset_o = rst_sync_q;

endmodule

`default_nettype wire

// File: rst_seq/rst_seq_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module rst_seq_fsm
(
   input  logic                      sys_clk,
   input  logic                      reset_in,
   input  logic                      heartbeat_i,   // step enable
   input  logic                      seq_reset_i,   // synchronized restart
   input  logic                      cclk_lock_i,   // synchronized core lock
   output elink_clk_pkg::rst_state_t state_o,
   output logic                      pll_reset_o,
   output logic                      idelay_reset_o,
   output logic                      cclk_reset_o,
   output logic                      chip_resetn_o,   // active low to remote chip
   output logic                      link_reset_o
);

   elink_clk_pkg::rst_state_t state_q;

   //############################################################
   // sequence, at most one step per heartbeat
   //############################################################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in || seq_reset_i)
      begin
         state_q <= elink_clk_pkg::RST_ALL;   // restart from the top
      end
      else if (heartbeat_i)
      begin
         case (state_q)
            elink_clk_pkg::RST_ALL:
               state_q <= elink_clk_pkg::START_CCLK;
            elink_clk_pkg::START_CCLK:
            begin
               if (cclk_lock_i)   // stall here until pll locks
                  state_q <= elink_clk_pkg::STOP_CCLK;
            end
            elink_clk_pkg::STOP_CCLK:
               state_q <= elink_clk_pkg::START_CHIP;
            elink_clk_pkg::START_CHIP:
               state_q <= elink_clk_pkg::HOLD;
            elink_clk_pkg::HOLD:
            begin
               if (cclk_lock_i)   // relock after clock restart
                  state_q <= elink_clk_pkg::TX_ACTIVE;
            end
            elink_clk_pkg::TX_ACTIVE:
               state_q <= elink_clk_pkg::ACTIVE;
            elink_clk_pkg::ACTIVE:
               state_q <= elink_clk_pkg::ACTIVE;   // parked until next restart
            default:
               state_q <= elink_clk_pkg::RST_ALL;   // code 7 never reached
         endcase
      end
   end

   assign state_o = state_q;

   //############################################################
   // control decode, straight from the state register
   //############################################################

   // pll kept in reset until link fully up
   assign pll_reset_o = (state_q != elink_clk_pkg::ACTIVE);

   // delay controller released once core clock has locked
   assign idelay_reset_o = (state_q == elink_clk_pkg::RST_ALL) |
                           (state_q == elink_clk_pkg::START_CCLK);

   // clock stopped around the chip reset edge
   assign cclk_reset_o = (state_q == elink_clk_pkg::RST_ALL) |
                         (state_q == elink_clk_pkg::STOP_CCLK) |
                         (state_q == elink_clk_pkg::START_CHIP);

   assign chip_resetn_o = (state_q == elink_clk_pkg::START_CHIP) |
                          (state_q == elink_clk_pkg::HOLD) |
                          (state_q == elink_clk_pkg::TX_ACTIVE) |
                          (state_q == elink_clk_pkg::ACTIVE);

   // link logic only runs in the last two states
   assign link_reset_o = (state_q != elink_clk_pkg::TX_ACTIVE) &
                         (state_q != elink_clk_pkg::ACTIVE);

endmodule

`default_nettype wire

// File: src/elink_clk_regs.sv
`default_nettype none
`timescale 1ns/10ps

module elink_clk_regs
(
   input  logic                                 sys_clk,
   input  logic                                 reset_in,
   // write address and data
   input  logic [elink_clk_pkg::AXI_AW-1:0]     awaddr_i,
   input  logic                                 awvalid_i,
   output logic                                 awready_o,
   input  logic [elink_clk_pkg::AXI_DW-1:0]     wdata_i,
   input  logic [elink_clk_pkg::AXI_DW/8-1:0]   wstrb_i,
   input  logic                                 wvalid_i,
   output logic                                 wready_o,
   // write response
   output logic [1:0]                           bresp_o,
   output logic                                 bvalid_o,
   input  logic                                 bready_i,
   // read
   input  logic [elink_clk_pkg::AXI_AW-1:0]     araddr_i,
   input  logic                                 arvalid_i,
   output logic                                 arready_o,
   output logic [elink_clk_pkg::AXI_DW-1:0]     rdata_o,
   output logic [1:0]                           rresp_o,
   output logic                                 rvalid_o,
   input  logic                                 rready_i,
   // sequencer side
   input  logic                                 cclk_lock_i,
   input  logic                                 rx_lock_i,
   input  elink_clk_pkg::rst_state_t            state_i,
   output logic                                 soft_en_o
);

   logic                                  wr_take;      // write accepted this cycle
   logic                                  rd_take;      // read accepted this cycle
   logic                                  aw_hit;       // write address is mapped
   logic                                  wr_ctrl;
   logic                                  wr_stat;
   logic                                  cclk_lock_q;  // status stage and edge detect
   logic                                  rx_lock_q;
   elink_clk_pkg::rst_state_t             state_q;
   logic                                  link_up;
   logic                                  loss_evt;
   logic                                  lost_q;       // sticky
   logic [elink_clk_pkg::LOSS_CNT_W-1:0]  loss_cnt_q;
   logic [elink_clk_pkg::AXI_DW-1:0]      rd_word;
   logic                                  rd_err;

   //############################################################
   // write path
   //############################################################

   // both channels together, one outstanding response
   assign wr_take   = awvalid_i & wvalid_i & ~bvalid_o;
   assign awready_o = wr_take;
   assign wready_o  = wr_take;

   assign aw_hit  = (awaddr_i == elink_clk_pkg::ADDR_CTRL) |
                    (awaddr_i == elink_clk_pkg::ADDR_STATUS) |
                    (awaddr_i == elink_clk_pkg::ADDR_LOSS);   // loss write ignored
   assign wr_ctrl = wr_take & (awaddr_i == elink_clk_pkg::ADDR_CTRL);
   assign wr_stat = wr_take & (awaddr_i == elink_clk_pkg::ADDR_STATUS);

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
         bvalid_o <= 1'b0;
      else if (wr_take)
         bvalid_o <= 1'b1;
      else if (bready_i)
         bvalid_o <= 1'b0;   // held until master takes it
   end

   always_ff @(posedge sys_clk)
   begin
      if (wr_take)
         bresp_o <= aw_hit ? elink_clk_pkg::RESP_OKAY : elink_clk_pkg::RESP_SLVERR;
   end

   // soft enable, on out of reset
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
         soft_en_o <= 1'b1;
      else if (wr_ctrl && wstrb_i[elink_clk_pkg::CTRL_EN_BIT/8])
         soft_en_o <= wdata_i[elink_clk_pkg::CTRL_EN_BIT];
   end

   //############################################################
   // status stage and lock loss tracking
   //############################################################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         cclk_lock_q <= 1'b0;   // no false falling edge after reset
         rx_lock_q   <= 1'b0;
         state_q     <= elink_clk_pkg::RST_ALL;
      end
      else
      begin
         cclk_lock_q <= cclk_lock_i;
         rx_lock_q   <= rx_lock_i;
         state_q     <= state_i;
      end
   end

   // only losses seen once the link is carrying traffic count
   assign link_up  = (state_i == elink_clk_pkg::TX_ACTIVE) |
                     (state_i == elink_clk_pkg::ACTIVE);
   assign loss_evt = cclk_lock_q & ~cclk_lock_i & link_up;   // falling edge

   always_ff @(posedge sys_clk)
   begin
      if (reset_in || wr_stat)   // clear beats a same cycle loss
      begin
         lost_q     <= 1'b0;
         loss_cnt_q <= '0;
      end
      else if (loss_evt)
      begin
         lost_q <= 1'b1;
         if (loss_cnt_q != '1)   // saturate
            loss_cnt_q <= loss_cnt_q + 1'b1;
      end
   end

   //############################################################
   // read path
   //############################################################
   assign arready_o = ~rvalid_o;   // blocked while a response waits
   assign rd_take   = arvalid_i & arready_o;

   always_comb
   begin
      rd_word = '0;
      rd_err  = 1'b0;
      case (araddr_i)
         elink_clk_pkg::ADDR_CTRL:
            rd_word[elink_clk_pkg::CTRL_EN_BIT] = soft_en_o;
         elink_clk_pkg::ADDR_STATUS:
         begin
            rd_word[2:0]                              = state_q;   // state field
            rd_word[elink_clk_pkg::STAT_CCLK_LOCK_BIT] = cclk_lock_q;
            rd_word[elink_clk_pkg::STAT_RX_LOCK_BIT]   = rx_lock_q;
            rd_word[elink_clk_pkg::STAT_LOST_BIT]      = lost_q;
         end
         elink_clk_pkg::ADDR_LOSS:
            rd_word[elink_clk_pkg::LOSS_CNT_W-1:0] = loss_cnt_q;
         default:
            rd_err = 1'b1;   // unmapped, data stays zero
      endcase
   end

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
         rvalid_o <= 1'b0;
      else if (rd_take)
         rvalid_o <= 1'b1;
      else if (rready_i)
         rvalid_o <= 1'b0;
   end

   // captured at accept, stable while rvalid holds
   always_ff @(posedge sys_clk)
   begin
      if (rd_take)
      begin
         rdata_o <= rd_word;
         rresp_o <= rd_err ? elink_clk_pkg::RESP_SLVERR : elink_clk_pkg::RESP_OKAY;
      end
   end

endmodule

`default_nettype wire

// File: src/elink_clk_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module elink_clk_ctrl
(
   input  logic                                 sys_clk,
   input  logic                                 reset_in,
   // register port
   input  logic [elink_clk_pkg::AXI_AW-1:0]     awaddr_i,
   input  logic                                 awvalid_i,
   output logic                                 awready_o,
   input  logic [elink_clk_pkg::AXI_DW-1:0]     wdata_i,
   input  logic [elink_clk_pkg::AXI_DW/8-1:0]   wstrb_i,
   input  logic                                 wvalid_i,
   output logic                                 wready_o,
   output logic [1:0]                           bresp_o,
   output logic                                 bvalid_o,
   input  logic                                 bready_i,
   input  logic [elink_clk_pkg::AXI_AW-1:0]     araddr_i,
   input  logic                                 arvalid_i,
   output logic                                 arready_o,
   output logic [elink_clk_pkg::AXI_DW-1:0]     rdata_o,
   output logic [1:0]                           rresp_o,
   output logic                                 rvalid_o,
   input  logic                                 rready_i,
   // async inputs
   input  logic                                 cclk_locked_i,
   input  logic                                 rx_locked_i,
   input  logic                                 elink_en_i,
   // reset and enable controls
   output logic                                 pll_reset_o,
   output logic                                 idelay_reset_o,
   output logic                                 cclk_reset_o,
   output logic                                 chip_resetn_o,
   output logic                                 link_reset_o
);

   logic                      heartbeat;    // step pace
   logic                      cclk_lock_s;  // synchronized locks
   logic                      rx_lock_s;
   logic                      seq_reset;
   logic                      soft_en;
   elink_clk_pkg::rst_state_t seq_state;

   rst_heartbeat i_rst_heartbeat
   (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .heartbeat_o (heartbeat)
   );

   lock_sync i_lock_sync
   (
      .sys_clk       (sys_clk),
      .reset_in      (reset_in),
      .cclk_locked_i (cclk_locked_i),
      .rx_locked_i   (rx_locked_i),
      .elink_en_i    (elink_en_i),
      .soft_en_i     (soft_en),
      .cclk_lock_o   (cclk_lock_s),
      .rx_lock_o     (rx_lock_s),
      .seq_reset_o   (seq_reset)
   );

   rst_seq_fsm i_rst_seq_fsm
   (
      .sys_clk        (sys_clk),
      .reset_in       (reset_in),
      .heartbeat_i    (heartbeat),
      .seq_reset_i    (seq_reset),
      .cclk_lock_i    (cclk_lock_s),
      .state_o        (seq_state),
      .pll_reset_o    (pll_reset_o),
      .idelay_reset_o (idelay_reset_o),
      .cclk_reset_o   (cclk_reset_o),
      .chip_resetn_o  (chip_resetn_o),
      .link_reset_o   (link_reset_o)
   );

   elink_clk_regs i_elink_clk_regs
   (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .awaddr_i    (awaddr_i),
      .awvalid_i   (awvalid_i),
      .awready_o   (awready_o),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .bresp_o     (bresp_o),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .araddr_i    (araddr_i),
      .arvalid_i   (arvalid_i),
      .arready_o   (arready_o),
      .rdata_o     (rdata_o),
      .rresp_o     (rresp_o),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i),
      .cclk_lock_i (cclk_lock_s),
      .rx_lock_i   (rx_lock_s),
      .state_i     (seq_state),
      .soft_en_o   (soft_en)
   );

endmodule

`default_nettype wire

// File: test/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// AXI4-Lite master tasks entered and left 1 ns after a rising edge
// stall keeps bready/rready low that many cycles once valid shows
task automatic axil_write
(
   input logic [elink_clk_pkg::AXI_AW-1:0] addr,
   input logic [elink_clk_pkg::AXI_DW-1:0] data,
   input logic [1:0]                       exp_resp,
   input int                               stall
);
   logic [1:0] resp_q;
   awaddr  = addr;
   wdata   = data;
   wstrb   = '1;
   awvalid = 1'b1;
   wvalid  = 1'b1;
   @(negedge sys_clk);
   while (!(awready && wready))
      @(negedge sys_clk);
   @(posedge sys_clk);   // both channels taken here
   #1;
   awvalid = 1'b0;
   wvalid  = 1'b0;
   @(negedge sys_clk);
   while (!bvalid)
      @(negedge sys_clk);
   resp_q = bresp;
   repeat (stall)
   begin
      @(negedge sys_clk);
      assert (bvalid && bresp == resp_q)
      else
      begin
         errors++;
         $display("CHECK FAILED bvalid/bresp held: bvalid %h bresp %h", bvalid, bresp);
      end
      assert (!awready && !wready)   // no new write while response waits
      else
      begin
         errors++;
         $display("CHECK FAILED awready/wready pending: awready %h wready %h", awready, wready);
      end
   end
   assert (resp_q == exp_resp)
   else
   begin
      errors++;
      $display("CHECK FAILED bresp: got %h expected %h", resp_q, exp_resp);
   end
   @(posedge sys_clk);
   #1;
   bready = 1'b1;
   @(posedge sys_clk);   // response consumed
   #1;
   bready = 1'b0;
endtask

task automatic axil_read
(
   input  logic [elink_clk_pkg::AXI_AW-1:0] addr,
   input  logic [1:0]                       exp_resp,
   input  int                               stall,
   output logic [elink_clk_pkg::AXI_DW-1:0] data
);
   logic [1:0] resp_q;
   araddr  = addr;
   arvalid = 1'b1;
   @(negedge sys_clk);
   while (!arready)
      @(negedge sys_clk);
   @(posedge sys_clk);
   #1;
   arvalid = 1'b0;
   @(negedge sys_clk);
   while (!rvalid)
      @(negedge sys_clk);
   data   = rdata;
   resp_q = rresp;
   repeat (stall)
   begin
      @(negedge sys_clk);
      assert (rvalid && rdata == data && rresp == resp_q)   // must not move
      else
      begin
         errors++;
         $display("CHECK FAILED rvalid/rdata held: rvalid %h rdata %h", rvalid, rdata);
      end
      assert (!arready)   // read channel blocked
      else
      begin
         errors++;
         $display("CHECK FAILED arready pending: got %h expected %h", arready, 1'b0);
      end
   end
   assert (resp_q == exp_resp)
   else
   begin
      errors++;
      $display("CHECK FAILED rresp: got %h expected %h", resp_q, exp_resp);
   end
   @(posedge sys_clk);
   #1;
   rready = 1'b1;
   @(posedge sys_clk);
   #1;
   rready = 1'b0;
endtask

`endif

// File: test/tb_elink_clk_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module tb_elink_clk_ctrl;

   typedef struct packed
   {
      logic       cclk;      // async inputs for the row
      logic       rx;
      logic       en;
      logic [1:0] op;        // 0 none, 1 write CTRL, 2 write STATUS
      logic       wval;      // soft enable for a CTRL write
      logic [3:0] wait_hb;   // settle time in heartbeats
      logic [2:0] state;     // expected sequencer state
      logic [4:0] ctrl;      // {pll, idelay, cclk, chip_n, link}
      logic       lost;      // sticky flag
      logic [7:0] loss;      // loss count
   } row_t;

   logic                               sys_clk;
   logic                               reset_in;
   logic [elink_clk_pkg::AXI_AW-1:0]   awaddr;
   logic                               awvalid;
   logic                               awready;
   logic [elink_clk_pkg::AXI_DW-1:0]   wdata;
   logic [elink_clk_pkg::AXI_DW/8-1:0] wstrb;
   logic                               wvalid;
   logic                               wready;
   logic [1:0]                         bresp;
   logic                               bvalid;
   logic                               bready;
   logic [elink_clk_pkg::AXI_AW-1:0]   araddr;
   logic                               arvalid;
   logic                               arready;
   logic [elink_clk_pkg::AXI_DW-1:0]   rdata;
   logic [1:0]                         rresp;
   logic                               rvalid;
   logic                               rready;
   logic                               cclk_locked;   // async side
   logic                               rx_locked;
   logic                               elink_en;
   logic                               pll_reset;
   logic                               idelay_reset;
   logic                               cclk_reset;
   logic                               chip_resetn;
   logic                               link_reset;
   logic [4:0]                         ctrl_now;
   logic [4:0]                         ctrl_of_state [0:6];   // decode table per state
   row_t                               rows [$];
   int                                 errors;
   int                                 cycle_cnt;
   int                                 timeout_limit;
   int                                 rel_cycles;
   int                                 mon_state;
   int                                 prev_state;
   logic                               mon_en;
   integer                             seed;
   logic [elink_clk_pkg::AXI_DW-1:0]   rd;

   assign ctrl_now = {pll_reset, idelay_reset, cclk_reset, chip_resetn, link_reset};

   elink_clk_ctrl i_elink_clk_ctrl
   (
      .sys_clk        (sys_clk),
      .reset_in       (reset_in),
      .awaddr_i       (awaddr),
      .awvalid_i      (awvalid),
      .awready_o      (awready),
      .wdata_i        (wdata),
      .wstrb_i        (wstrb),
      .wvalid_i       (wvalid),
      .wready_o       (wready),
      .bresp_o        (bresp),
      .bvalid_o       (bvalid),
      .bready_i       (bready),
      .araddr_i       (araddr),
      .arvalid_i      (arvalid),
      .arready_o      (arready),
      .rdata_o        (rdata),
      .rresp_o        (rresp),
      .rvalid_o       (rvalid),
      .rready_i       (rready),
      .cclk_locked_i  (cclk_locked),
      .rx_locked_i    (rx_locked),
      .elink_en_i     (elink_en),
      .pll_reset_o    (pll_reset),
      .idelay_reset_o (idelay_reset),
      .cclk_reset_o   (cclk_reset),
      .chip_resetn_o  (chip_resetn),
      .link_reset_o   (link_reset)
   );

   `include "tb_axil_tasks.svh"

   initial
   begin
      sys_clk = 1'b0;
      forever
         #2 sys_clk = ~sys_clk;   // 4 ns period
   end

   // STATUS word built from the register map
   function automatic logic [31:0] status_word(input logic [2:0] st, input logic cl,
                                               input logic rl, input logic lost);
      logic [31:0] w;
      w = '0;
      w[2:0] = st;
      w[elink_clk_pkg::STAT_CCLK_LOCK_BIT] = cl;
      w[elink_clk_pkg::STAT_RX_LOCK_BIT]   = rl;
      w[elink_clk_pkg::STAT_LOST_BIT]      = lost;
      return w;
   endfunction

   function automatic int state_of_ctrl(input logic [4:0] c);
      for (int i = 0; i < 7; i++)
         if (ctrl_of_state[i] === c)
            return i;
      return -1;   // no state drives this pattern
   endfunction

   task automatic add_row(input logic cl, input logic rl, input logic en, input logic [1:0] op,
                          input logic wv, input logic [3:0] hb, input logic [2:0] st,
                          input logic [4:0] ct, input logic lost, input logic [7:0] loss);
      row_t r;
      r = '{cl, rl, en, op, wv, hb, st, ct, lost, loss};
      rows.push_back(r);
   endtask

   task automatic apply_row(input row_t r);
      int          jit;
      logic [31:0] wd;
      logic [31:0] rd_val;
      logic [31:0] exp_w;
      wd = '0;
      wd[elink_clk_pkg::CTRL_EN_BIT] = r.wval;
      if (r.op == 2'd1)
         axil_write(elink_clk_pkg::ADDR_CTRL, wd, elink_clk_pkg::RESP_OKAY, 0);
      else if (r.op == 2'd2)
         axil_write(elink_clk_pkg::ADDR_STATUS, wd, elink_clk_pkg::RESP_OKAY, 0);
      if ({r.cclk, r.rx, r.en} != {cclk_locked, rx_locked, elink_en})
      begin
         jit = {$random(seed)} % 16;   // land anywhere inside a heartbeat
         repeat (jit)
         begin
            @(posedge sys_clk);
            #1;
         end
         cclk_locked = r.cclk;
         rx_locked   = r.rx;
         elink_en    = r.en;
      end
      repeat (r.wait_hb * 16)
         @(posedge sys_clk);
      #1;
      axil_read(elink_clk_pkg::ADDR_STATUS, elink_clk_pkg::RESP_OKAY, 0, rd_val);
      exp_w = status_word(r.state, r.cclk, r.rx, r.lost);
      assert (rd_val == exp_w)
      else
      begin
         errors++;
         $display("CHECK FAILED status: got %h expected %h", rd_val, exp_w);
      end
      assert (ctrl_now == r.ctrl && ctrl_now == ctrl_of_state[rd_val[2:0]])
      else
      begin
         errors++;
         $display("CHECK FAILED controls: got %h expected %h", ctrl_now, r.ctrl);
      end
      axil_read(elink_clk_pkg::ADDR_LOSS, elink_clk_pkg::RESP_OKAY, 0, rd_val);
      assert (rd_val == {24'h0, r.loss})
      else
      begin
         errors++;
         $display("CHECK FAILED loss: got %h expected %h", rd_val, r.loss);
      end
   endtask

   //############################################################
   // monitor, outputs must decode to a state, legal steps only
   //############################################################
   always @(negedge sys_clk)
   begin
      if (mon_en)
      begin
         mon_state = state_of_ctrl(ctrl_now);
         assert (mon_state >= 0)
         else
         begin
            errors++;
            $display("controls %h match no sequencer state", ctrl_now);
         end
         if (mon_state >= 0)
         begin
            assert (mon_state == prev_state || mon_state == prev_state + 1 || mon_state == 0)
            else
            begin
               errors++;
               $display("illegal sequencer step from state %0d to %0d", prev_state, mon_state);
            end
            prev_state = mon_state;
         end
      end
   end

   // timeout, table waits plus bus and jitter slack
   initial
   begin
      cycle_cnt = 0;
      wait (timeout_limit != 0);
      while (cycle_cnt < timeout_limit)
      begin
         @(posedge sys_clk);
         cycle_cnt++;
      end
      errors++;
      $display("run did not finish within %0d cycles", timeout_limit);
      $display("errors %0d", errors);
      $display("Errors found");
      $finish;
   end

   initial
   begin
      reset_in    = 1'b1;
      awaddr      = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      cclk_locked = 1'b1;
      rx_locked   = 1'b1;
      elink_en    = 1'b1;
      errors      = 0;
      mon_en      = 1'b0;
      prev_state  = 0;
      seed        = 32'hcf71c7fb;
      timeout_limit = 0;
      ctrl_of_state[0] = 5'b11101;   // RST_ALL
      ctrl_of_state[1] = 5'b11001;   // START_CCLK
      ctrl_of_state[2] = 5'b10101;   // STOP_CCLK
      ctrl_of_state[3] = 5'b10111;   // START_CHIP
      ctrl_of_state[4] = 5'b10011;   // HOLD
      ctrl_of_state[5] = 5'b10010;   // TX_ACTIVE
      ctrl_of_state[6] = 5'b00010;   // ACTIVE

      // cclk rx en op wval hb state ctrl lost loss
      add_row(1, 1, 1, 0, 0, 2, elink_clk_pkg::ACTIVE,     5'b00010, 0, 8'd0);
      add_row(0, 1, 1, 0, 0, 2, elink_clk_pkg::ACTIVE,     5'b00010, 1, 8'd1);   // loss one
      add_row(1, 1, 1, 0, 0, 2, elink_clk_pkg::ACTIVE,     5'b00010, 1, 8'd1);
      add_row(0, 1, 1, 0, 0, 2, elink_clk_pkg::ACTIVE,     5'b00010, 1, 8'd2);   // loss two
      add_row(1, 0, 1, 0, 0, 2, elink_clk_pkg::ACTIVE,     5'b00010, 1, 8'd2);   // rx bit
      add_row(1, 1, 1, 2, 0, 1, elink_clk_pkg::ACTIVE,     5'b00010, 0, 8'd0);   // clear
      add_row(1, 1, 0, 0, 0, 2, elink_clk_pkg::RST_ALL,    5'b11101, 0, 8'd0);   // pin off
      add_row(1, 1, 1, 0, 0, 8, elink_clk_pkg::ACTIVE,     5'b00010, 0, 8'd0);
      add_row(1, 1, 1, 1, 0, 2, elink_clk_pkg::RST_ALL,    5'b11101, 0, 8'd0);   // soft off
      add_row(1, 1, 1, 1, 1, 8, elink_clk_pkg::ACTIVE,     5'b00010, 0, 8'd0);
      add_row(1, 1, 1, 1, 0, 2, elink_clk_pkg::RST_ALL,    5'b11101, 0, 8'd0);
      add_row(0, 1, 1, 0, 0, 1, elink_clk_pkg::RST_ALL,    5'b11101, 0, 8'd0);   // no lock
      add_row(0, 1, 1, 1, 1, 3, elink_clk_pkg::START_CCLK, 5'b11001, 0, 8'd0);   // stall
      add_row(1, 1, 1, 0, 0, 8, elink_clk_pkg::ACTIVE,     5'b00010, 0, 8'd0);   // finish

      foreach (rows[i])
         timeout_limit += rows[i].wait_hb * 16;
      timeout_limit += 500;

      repeat (2)
         @(posedge sys_clk);
      #1;
      reset_in = 1'b0;
      mon_en   = 1'b1;

      // both locks high, count cycles until pll_reset drops
      rel_cycles = 0;
      while (pll_reset && rel_cycles < 200)
      begin
         @(negedge sys_clk);
         rel_cycles++;
      end
      assert (rel_cycles <= 114)
      else
      begin
         errors++;
         $display("sequencer needed %0d cycles after reset to reach ACTIVE", rel_cycles);
      end
      @(posedge sys_clk);
      #1;

      foreach (rows[i])
         apply_row(rows[i]);

      //############################################################
      // unmapped address and held responses
      //############################################################
      axil_write(4'hc, 32'h0, elink_clk_pkg::RESP_SLVERR, 3);
      axil_read(4'hc, elink_clk_pkg::RESP_SLVERR, 3, rd);
      assert (rd == 32'h0)
      else
      begin
         errors++;
         $display("CHECK FAILED rdata: got %h expected %h", rd, 32'h0);
      end
      axil_read(elink_clk_pkg::ADDR_CTRL, elink_clk_pkg::RESP_OKAY, 3, rd);
      assert (rd == 32'h1)   // enable survives the stray write
      else
      begin
         errors++;
         $display("CHECK FAILED ctrl: got %h expected %h", rd, 32'h1);
      end

      $display("rows %0d errors %0d", rows.size(), errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+test
common/elink_clk_pkg.sv
rst_seq/rst_heartbeat.sv
rst_seq/lock_sync.sv
rst_seq/rst_seq_fsm.sv
src/elink_clk_regs.sv
src/elink_clk_ctrl.sv
test/tb_elink_clk_ctrl.sv

// File: Bender.yml
package:
  name: elink_clk_ctrl

sources:
  # shared package first
  - common/elink_clk_pkg.sv
  # reset sequencer
  - rst_seq/rst_heartbeat.sv
  - rst_seq/lock_sync.sv
  - rst_seq/rst_seq_fsm.sv
  # register port and top level
  - src/elink_clk_regs.sv
  - src/elink_clk_ctrl.sv
  # testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_elink_clk_ctrl.sv
